//--- hdl/ext_dev_pkg.sv
// ======================================================================
// Shared types and constants of the external device subsystem.
// Import with a wildcard in the module header.
// ======================================================================
package ext_dev_pkg;

  // RAM sizing; word index is taken from addr[8:2]
  localparam int unsigned MEM_NUM_WORDS = 128;
  localparam int unsigned MEM_ADDR_W    = $clog2(MEM_NUM_WORDS);
  localparam int unsigned MEM_GNT_DELAY = 2;
  localparam int unsigned GNT_CNT_W     = $clog2(MEM_GNT_DELAY + 1);

  // Copy length in words
  localparam int unsigned SIZE_W = 8;

  // GPIO counter limit
  localparam int unsigned GPIO_CNT_MAX = 16;
  localparam int unsigned GPIO_CNT_W   = $clog2(GPIO_CNT_MAX);

  // Memcopy register map
  localparam logic [31:0] REG_SRC_PTR = 32'h0;
  localparam logic [31:0] REG_DST_PTR = 32'h4;
  localparam logic [31:0] REG_SIZE    = 32'h8;
  localparam logic [31:0] REG_STATUS  = 32'hC;

  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic [31:0]       src;
    logic [31:0]       dst;
    logic [SIZE_W-1:0] size;
  } memcopy_cmd_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_WR_REQ,
    ST_WR_WAIT
  } copy_state_e;

endpackage

//--- hdl/slow_memory.sv
// ======================================================================
// Word RAM behind an OBI slave port with a fixed grant delay.
// ======================================================================
module slow_memory
  import ext_dev_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  obi_req_t obi_req_i,
  output obi_rsp_t obi_rsp_o
);

  logic [GNT_CNT_W-1:0]  wait_cnt_q;
  logic                  gnt;
  logic [MEM_ADDR_W-1:0] word_idx;
  logic [31:0]           mem_q [MEM_NUM_WORDS];
  logic [31:0]           rdata_q;
  logic                  rvalid_q;

  // Upper address bits are ignored, so the RAM aliases every 512 bytes
  assign word_idx = obi_req_i.addr[MEM_ADDR_W+1:2];
  assign gnt      = obi_req_i.req && (wait_cnt_q == GNT_CNT_W'(MEM_GNT_DELAY));

  // Cycles the current request has been held
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_cnt_q <= '0;
    end else if (!obi_req_i.req || gnt) begin
      wait_cnt_q <= '0;
    end else begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt && obi_req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (obi_req_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= obi_req_i.wdata[8*b +: 8];
        end
      end
    end
    if (gnt && !obi_req_i.we) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  // One response per grant, reads and writes alike
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
    end
  end

  always_comb begin
    obi_rsp_o.gnt    = gnt;
    obi_rsp_o.rvalid = rvalid_q;
    obi_rsp_o.rdata  = rdata_q;
  end

endmodule

//--- hdl/obi_arbiter.sv
// ======================================================================
// Two-master OBI arbiter with fixed priority for master 0.
// Only one transfer is in flight; the response returns to its owner.
// ======================================================================
module obi_arbiter
  import ext_dev_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  obi_req_t m0_req_i,
  input  obi_req_t m1_req_i,
  output obi_rsp_t m0_rsp_o,
  output obi_rsp_t m1_rsp_o,
  output obi_req_t s_req_o,
  input  obi_rsp_t s_rsp_i
);

  logic sel_m1;
  logic pending_q;
  logic owner_q;

  // Master 1 only gets the slave when master 0 is quiet
  assign sel_m1 = !m0_req_i.req;

  always_comb begin
    s_req_o     = sel_m1 ? m1_req_i : m0_req_i;
    // Hold off new requests until the pending response is back
    s_req_o.req = !pending_q && (m0_req_i.req || m1_req_i.req);
  end

  always_comb begin
    m0_rsp_o.gnt    = s_rsp_i.gnt && !sel_m1;
    m1_rsp_o.gnt    = s_rsp_i.gnt && sel_m1;
    m0_rsp_o.rvalid = s_rsp_i.rvalid && !owner_q;
    m1_rsp_o.rvalid = s_rsp_i.rvalid && owner_q;
    m0_rsp_o.rdata  = owner_q ? '0 : s_rsp_i.rdata;
    m1_rsp_o.rdata  = owner_q ? s_rsp_i.rdata : '0;
  end

  // Owner is kept from grant until its rvalid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      owner_q   <= 1'b0;
    end else if (s_rsp_i.gnt) begin
      pending_q <= 1'b1;
      owner_q   <= sel_m1;
    end else if (s_rsp_i.rvalid) begin
      pending_q <= 1'b0;
    end
  end

endmodule

//--- hdl/memcopy_regs.sv
// ======================================================================
// Register-bus front end of the memcopy peripheral.
// A size write starts the engine; done raises the interrupt.
// ======================================================================
module memcopy_regs
  import ext_dev_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  reg_req_t     reg_req_i,
  output reg_rsp_t     reg_rsp_o,
  output memcopy_cmd_t cmd_o,
  output logic         start_o,
  input  logic         done_i,
  output logic         intr_o
);

  logic [31:0]       src_q;
  logic [31:0]       dst_q;
  logic [SIZE_W-1:0] size_q;
  logic              busy_q;
  logic              done_q;
  logic              start_q;
  logic              wr_en;
  logic              size_wr_ok;
  logic              done_clr;

  assign wr_en      = reg_req_i.valid && reg_req_i.write;
  assign size_wr_ok = wr_en && (reg_req_i.addr == REG_SIZE) && !busy_q;
  // Done is write-one-to-clear
  assign done_clr   = wr_en && (reg_req_i.addr == REG_STATUS) && reg_req_i.wstrb[0]
                      && reg_req_i.wdata[STATUS_DONE_BIT];

  // Pointers honor byte strobes
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (wr_en && reg_req_i.wstrb[b] && (reg_req_i.addr == REG_SRC_PTR)) begin
        src_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
      end
      if (wr_en && reg_req_i.wstrb[b] && (reg_req_i.addr == REG_DST_PTR)) begin
        dst_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      size_q  <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (size_wr_ok) begin
        size_q <= reg_req_i.wdata[SIZE_W-1:0];
        // A zero size is stored but starts nothing
        if (reg_req_i.wdata[SIZE_W-1:0] != '0) begin
          start_q <= 1'b1;
          busy_q  <= 1'b1;
        end
      end
      if (done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else if (done_clr) begin
        done_q <= 1'b0;
      end
    end
  end

  // Zero wait states
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (reg_req_i.addr)
      REG_SRC_PTR: reg_rsp_o.rdata = src_q;
      REG_DST_PTR: reg_rsp_o.rdata = dst_q;
      REG_SIZE: begin
        reg_rsp_o.rdata = 32'(size_q);
        reg_rsp_o.error = wr_en && busy_q;
      end
      REG_STATUS: begin
        reg_rsp_o.rdata[STATUS_BUSY_BIT] = busy_q;
        reg_rsp_o.rdata[STATUS_DONE_BIT] = done_q;
      end
      default: reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  always_comb begin
    cmd_o.src  = src_q;
    cmd_o.dst  = dst_q;
    cmd_o.size = size_q;
  end

  assign start_o = start_q;
  assign intr_o  = done_q;

endmodule

//--- hdl/memcopy_engine.sv
// ======================================================================
// Copy engine: an OBI master that moves one word per read/write pair.
// Started by a pulse from the register block, answers with done.
// ======================================================================
module memcopy_engine
  import ext_dev_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  memcopy_cmd_t cmd_i,
  input  logic         start_i,
  output obi_req_t     obi_req_o,
  input  obi_rsp_t     obi_rsp_i,
  output logic         done_o
);

  copy_state_e       state_q;
  copy_state_e       state_d;
  memcopy_cmd_t      cmd_q;
  logic [SIZE_W-1:0] idx_q;
  logic [31:0]       data_q;
  logic [31:0]       word_off;
  logic              last_word;
  logic              done_q;

  assign word_off  = 32'(idx_q) << 2;
  assign last_word = (idx_q == cmd_q.size - SIZE_W'(1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i && (cmd_i.size != '0)) begin
          state_d = ST_RD_REQ;
        end
      end
      ST_RD_REQ: begin
        if (obi_rsp_i.gnt) begin
          state_d = ST_RD_WAIT;
        end
      end
      ST_RD_WAIT: begin
        if (obi_rsp_i.rvalid) begin
          state_d = ST_WR_REQ;
        end
      end
      ST_WR_REQ: begin
        if (obi_rsp_i.gnt) begin
          state_d = ST_WR_WAIT;
        end
      end
      ST_WR_WAIT: begin
        if (obi_rsp_i.rvalid) begin
          state_d = last_word ? ST_IDLE : ST_RD_REQ;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Bus request follows the state; fields are stable while req is held
  always_comb begin
    obi_req_o.req   = 1'b0;
    obi_req_o.we    = 1'b0;
    obi_req_o.be    = 4'hf;
    obi_req_o.addr  = '0;
    obi_req_o.wdata = '0;
    if (state_q == ST_RD_REQ) begin
      obi_req_o.req  = 1'b1;
      obi_req_o.addr = cmd_q.src + word_off;
    end else if (state_q == ST_WR_REQ) begin
      obi_req_o.req   = 1'b1;
      obi_req_o.we    = 1'b1;
      obi_req_o.addr  = cmd_q.dst + word_off;
      obi_req_o.wdata = data_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= 1'b0;
      if (state_q == ST_IDLE) begin
        idx_q <= '0;
      end
      if ((state_q == ST_WR_WAIT) && obi_rsp_i.rvalid) begin
        idx_q  <= idx_q + 1'b1;
        done_q <= last_word;
      end
    end
  end

  // Command and data word
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && start_i) begin
      cmd_q <= cmd_i;
    end
    if ((state_q == ST_RD_WAIT) && obi_rsp_i.rvalid) begin
      data_q <= obi_rsp_i.rdata;
    end
  end

  assign done_o = done_q;

endmodule

//--- hdl/gpio_cnt.sv
// ======================================================================
// GPIO pulse counter: counts cycles with gpio_i high and pulses
// gpio_o once every GPIO_CNT_MAX such cycles.
// ======================================================================
module gpio_cnt
  import ext_dev_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic gpio_i,
  output logic gpio_o
);

  logic [GPIO_CNT_W-1:0] cnt_q;
  logic                  pulse_q;
  logic                  wrap;

  assign wrap = gpio_i && (cnt_q == GPIO_CNT_W'(GPIO_CNT_MAX - 1));

  // Count holds while the input is low
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q   <= '0;
      pulse_q <= 1'b0;
    end else begin
      pulse_q <= wrap;
      if (wrap) begin
        cnt_q <= '0;
      end else if (gpio_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign gpio_o = pulse_q;

endmodule

//--- hdl/ext_dev_top.sv
// ======================================================================
// External device subsystem top: slow RAM shared by the host port
// and the memcopy engine, plus the memcopy registers and GPIO counter.
// ======================================================================
module ext_dev_top
  import ext_dev_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  obi_req_t host_obi_req_i,
  output obi_rsp_t host_obi_rsp_o,
  input  logic     gpio_i,
  output logic     gpio_o,
  output logic     intr_o
);

  obi_req_t     mem_req;
  obi_rsp_t     mem_rsp;
  obi_req_t     dma_req;
  obi_rsp_t     dma_rsp;
  memcopy_cmd_t copy_cmd;
  logic         copy_start;
  logic         copy_done;

  slow_memory slow_ram_i (
    .clk_i,
    .reset_i,
    .obi_req_i(mem_req),
    .obi_rsp_o(mem_rsp)
  );

  // Host has priority over the copy engine
  obi_arbiter obi_arbiter_i (
    .clk_i,
    .reset_i,
    .m0_req_i(host_obi_req_i),
    .m1_req_i(dma_req),
    .m0_rsp_o(host_obi_rsp_o),
    .m1_rsp_o(dma_rsp),
    .s_req_o (mem_req),
    .s_rsp_i (mem_rsp)
  );

  memcopy_regs memcopy_regs_i (
    .clk_i,
    .reset_i,
    .reg_req_i,
    .reg_rsp_o,
    .cmd_o  (copy_cmd),
    .start_o(copy_start),
    .done_i (copy_done),
    .intr_o
  );

  memcopy_engine memcopy_engine_i (
    .clk_i,
    .reset_i,
    .cmd_i    (copy_cmd),
    .start_i  (copy_start),
    .obi_req_o(dma_req),
    .obi_rsp_i(dma_rsp),
    .done_o   (copy_done)
  );

  gpio_cnt gpio_cnt_i (
    .clk_i,
    .reset_i,
    .gpio_i,
    .gpio_o
  );

endmodule

//--- testbench/tb_ext_dev.sv
// ======================================================================
// Directed testbench for the external device subsystem. Drives the
// register bus, the host OBI port and gpio_i, and checks a memory model.
// ======================================================================
module tb_ext_dev
  import ext_dev_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_HALF_NS  = 4;
  localparam int unsigned HS_TIMEOUT   = 100;
  localparam int unsigned INTR_TIMEOUT = 600;
  // All tests together take about 1500 cycles of 8 ns
  localparam int unsigned WATCHDOG_NS  = 20000;

  logic     clk;
  logic     reset;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  obi_req_t host_req;
  obi_rsp_t host_rsp;
  logic     gpio_in;
  logic     gpio_out;
  logic     intr;

  logic [31:0] ref_mem [MEM_NUM_WORDS];
  string       cur_test;
  int          num_checks;
  int          num_errors;

  // GPIO reference counter
  int          gpio_model_cnt;
  logic        gpio_exp_pulse;
  logic        gpio_prev_in;

  ext_dev_top dut (
    .clk_i         (clk),
    .reset_i       (reset),
    .reg_req_i     (reg_req),
    .reg_rsp_o     (reg_rsp),
    .host_obi_req_i(host_req),
    .host_obi_rsp_o(host_rsp),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .intr_o        (intr)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF_NS clk = ~clk;
  end

  initial begin
    #WATCHDOG_NS;
    $display("ERROR watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("ERROR %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    num_errors++;
    $display("ERROR %s: %s", cur_test, msg);
  endtask

  task automatic reg_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    reg_req_t req;
    int       waited;
    req       = '0;
    req.valid = 1'b1;
    req.write = write;
    req.wstrb = 4'hf;
    req.addr  = addr;
    req.wdata = wdata;
    reg_req  <= req;
    rdata     = '0;
    err       = 1'b1;
    waited    = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!reg_rsp.ready && waited < HS_TIMEOUT);
    if (reg_rsp.ready) begin
      rdata = reg_rsp.rdata;
      err   = reg_rsp.error;
    end else begin
      report_failure($sformatf("register bus never gave ready at offset 0x%0h", addr));
    end
    reg_req <= '0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    reg_access(1'b1, addr, data, unused, err);
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    reg_access(1'b0, addr, '0, data, err);
  endtask

  task automatic obi_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    obi_req_t req;
    int       waited;
    req       = '0;
    req.req   = 1'b1;
    req.we    = we;
    req.be    = be;
    req.addr  = addr;
    req.wdata = wdata;
    host_req <= req;
    rdata     = 'x;
    waited    = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!host_rsp.gnt && waited < HS_TIMEOUT);
    host_req <= '0;
    if (!host_rsp.gnt) begin
      report_failure($sformatf("host request to 0x%0h was never granted", addr));
      return;
    end
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!host_rsp.rvalid && waited < HS_TIMEOUT);
    if (host_rsp.rvalid) begin
      rdata = host_rsp.rdata;
    end else begin
      report_failure($sformatf("no rvalid after grant at 0x%0h", addr));
    end
  endtask

  // Word index is addr[8:2], so the model aliases every 512 bytes too
  function automatic void model_write(logic [31:0] addr, logic [3:0] be, logic [31:0] data);
    int idx;
    idx = addr[8:2];
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ref_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  function automatic void model_copy(logic [31:0] src, logic [31:0] dst, int size);
    for (int i = 0; i < size; i++) begin
      model_write(dst + 4 * i, 4'hf, ref_mem[(src[8:2] + i) % MEM_NUM_WORDS]);
    end
  endfunction

  task automatic obi_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data);
    logic [31:0] unused;
    obi_access(1'b1, be, addr, data, unused);
    model_write(addr, be, data);
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] data);
    obi_access(1'b0, 4'hf, addr, '0, data);
  endtask

  task automatic check_word(input string what, input logic [31:0] addr);
    logic [31:0] data;
    obi_read(addr, data);
    check_value($sformatf("%s at 0x%0h", what, addr), ref_mem[addr[8:2]], data);
  endtask

  task automatic check_block(input string what, input logic [31:0] addr, input int n);
    for (int i = 0; i < n; i++) begin
      check_word(what, addr + 4 * i);
    end
  endtask

  task automatic preload_block(input logic [31:0] addr, input int n);
    for (int i = 0; i < n; i++) begin
      obi_write(addr + 4 * i, 4'hf, $urandom);
    end
  endtask

  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst, input int size);
    logic err;
    reg_write(REG_SRC_PTR, src, err);
    check_value("SRC_PTR write error", 0, err);
    reg_write(REG_DST_PTR, dst, err);
    check_value("DST_PTR write error", 0, err);
    reg_write(REG_SIZE, size, err);
    check_value("SIZE write error", 0, err);
  endtask

  task automatic wait_for_intr();
    int waited;
    waited = 0;
    while (intr !== 1'b1 && waited < INTR_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (intr !== 1'b1) begin
      report_failure($sformatf("copy raised no interrupt within %0d cycles", INTR_TIMEOUT));
    end
  endtask

  // Wait for the interrupt, compare the block, then clear done
  task automatic finish_copy(input logic [31:0] src, input logic [31:0] dst, input int size);
    logic [31:0] data;
    logic        err;
    wait_for_intr();
    model_copy(src, dst, size);
    reg_read(REG_STATUS, data, err);
    check_value("status after copy", 32'(1) << STATUS_DONE_BIT, data);
    check_block("copied word", dst, size);
    reg_write(REG_STATUS, 32'(1) << STATUS_DONE_BIT, err);
    check_value("status clear error", 0, err);
    @(posedge clk);
    check_value("intr_o after clear", 0, intr);
  endtask

  task automatic test_registers();
    logic [31:0] data;
    logic [31:0] val;
    logic        err;
    cur_test = "registers";
    check_value("intr_o after reset", 0, intr);
    check_value("gpio_o after reset", 0, gpio_out);
    check_value("host gnt after reset", 0, host_rsp.gnt);
    check_value("host rvalid after reset", 0, host_rsp.rvalid);
    reg_read(REG_STATUS, data, err);
    check_value("status after reset", 0, data);
    check_value("status read error", 0, err);
    val = $urandom;
    reg_write(REG_SRC_PTR, val, err);
    reg_read(REG_SRC_PTR, data, err);
    check_value("SRC_PTR readback", val, data);
    val = $urandom;
    reg_write(REG_DST_PTR, val, err);
    reg_read(REG_DST_PTR, data, err);
    check_value("DST_PTR readback", val, data);
    reg_read(32'h10, data, err);
    check_value("unmapped read error", 1, err);
    reg_write(32'h10, $urandom, err);
    check_value("unmapped write error", 1, err);
  endtask

  task automatic test_host_memory();
    logic [3:0] be;
    cur_test = "host_memory";
    for (int i = 0; i < 16; i++) begin
      obi_write(4 * i, 4'hf, $urandom);
      be = 4'($urandom);
      if (be == 4'h0) begin
        be = 4'h9;
      end
      obi_write(4 * i, be, $urandom);
    end
    check_block("host word", 32'h0, 16);
    // Same word through the upper alias
    obi_write(32'h214, 4'hf, $urandom);
    check_word("alias low", 32'h014);
    check_word("alias high", 32'h214);
  endtask

  task automatic test_copy();
    cur_test = "copy";
    preload_block(32'h080, 12);
    start_copy(32'h080, 32'h100, 12);
    finish_copy(32'h080, 32'h100, 12);
  endtask

  task automatic test_rejected_start();
    logic [31:0] data;
    logic        err;
    cur_test = "rejected_start";
    preload_block(32'h140, 32);
    start_copy(32'h140, 32'h040, 32);
    reg_read(REG_STATUS, data, err);
    check_value("status while busy", 32'(1) << STATUS_BUSY_BIT, data);
    reg_write(REG_SIZE, 5, err);
    check_value("size write while busy error", 1, err);
    reg_read(REG_SIZE, data, err);
    check_value("size after rejected write", 32, data);
    finish_copy(32'h140, 32'h040, 32);
    reg_write(REG_SIZE, 0, err);
    check_value("zero size write error", 0, err);
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      if (intr !== 1'b0) begin
        report_failure("interrupt raised after a zero size write");
        break;
      end
    end
    reg_read(REG_STATUS, data, err);
    check_value("status after zero size", 0, data);
  endtask

  task automatic test_shared_access();
    cur_test = "shared_access";
    preload_block(32'h0c0, 16);
    start_copy(32'h0c0, 32'h1c0, 16);
    // Host traffic competes with the running copy
    for (int i = 0; i < 8; i++) begin
      obi_write(4 * i, 4'hf, $urandom);
      check_word("host word during copy", 4 * i);
    end
    finish_copy(32'h0c0, 32'h1c0, 16);
    check_block("host word after copy", 32'h0, 8);
  endtask

  // Output lags the input by one cycle, so it is checked against the previous level
  task automatic gpio_cycle(input logic level, inout int pulses);
    gpio_in <= level;
    @(posedge clk);
    if (!gpio_prev_in && gpio_out) begin
      report_failure("gpio_o pulsed while gpio_i was low");
    end else begin
      check_value("gpio_o", gpio_exp_pulse, gpio_out);
    end
    if (gpio_out === 1'b1) begin
      pulses++;
    end
    // A full count of high cycles gives one pulse and starts over
    if (level) begin
      gpio_model_cnt++;
    end
    gpio_exp_pulse = (gpio_model_cnt == GPIO_CNT_MAX);
    if (gpio_exp_pulse) begin
      gpio_model_cnt = 0;
    end
    gpio_prev_in = level;
  endtask

  task automatic test_gpio();
    int m;
    int bursts [4];
    int pulses;
    cur_test       = "gpio";
    m              = GPIO_CNT_MAX;
    // Uneven bursts adding up to three full counts
    bursts         = '{m / 2 + 2, m - 2, m - 4, m / 2 + 4};
    pulses         = 0;
    gpio_model_cnt = 0;
    gpio_exp_pulse = 1'b0;
    gpio_prev_in   = 1'b0;
    foreach (bursts[k]) begin
      repeat (bursts[k]) gpio_cycle(1'b1, pulses);
      repeat (5) gpio_cycle(1'b0, pulses);
    end
    check_value("gpio pulse count", 3, pulses);
  endtask

  initial begin
    int unsigned seed_ret;
    seed_ret   = $urandom(32'h1f1b_9c88);
    num_checks = 0;
    num_errors = 0;
    cur_test   = "reset";
    reset      = 1'b1;
    reg_req    = '0;
    host_req   = '0;
    gpio_in    = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_registers();
    test_host_memory();
    test_copy();
    test_rejected_start();
    test_shared_access();
    test_gpio();
    $display("Summary: %0d checks, %0d errors", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
hdl/ext_dev_pkg.sv
hdl/slow_memory.sv
hdl/obi_arbiter.sv
hdl/memcopy_regs.sv
hdl/memcopy_engine.sv
hdl/gpio_cnt.sv
hdl/ext_dev_top.sv
testbench/tb_ext_dev.sv
